/* files.f */
+incdir+include
design/frame_wr_pkg.sv
design/channel_scheduler.sv
design/frame_addr_gen.sv
design/axi_burst_writer.sv
design/frame_writer_top.sv
verif/frame_writer_checker.sv
verif/tb_frame_writer.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the frame writer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_frame_writer \
    -f files.f \
    -o sim_frame_writer

# assertion failures are counted by the testbench, so the run goes on past them
out=$(./obj_dir/sim_frame_writer +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

/* verif/tb_frame_writer.sv */
`timescale 1ns/1ps
`include "frame_wr_defs.svh"

module tb_frame_writer;

    typedef struct packed {
        logic [`FW_NUM_CH-1:0] mask;   // bit n enables channel n
        int                    bpf;    // bursts per frame
        int                    stall;  // 0 never stalls, 3 stalls most
        int                    count;  // bursts served in this row
    } row_t;

    localparam int NUM_ROWS = 5;

    logic                     clk = 1'b0;
    logic                     rst;
    frame_wr_pkg::ch_status_t ch_status [`FW_NUM_CH];
    frame_wr_pkg::data_t      ch_data [`FW_NUM_CH];
    logic [`FW_NUM_CH-1:0]    ch_pop;
    frame_wr_pkg::axi_aw_t    aw;
    logic                     aw_valid;
    logic                     aw_ready;
    frame_wr_pkg::axi_w_t     w;
    logic                     w_valid;
    logic                     w_ready;
    frame_wr_pkg::axi_b_t     b;
    logic                     b_valid;
    logic                     b_ready;

    row_t rows [NUM_ROWS];

    // reference model of buffers, pointer, offsets and slots
    frame_wr_pkg::data_t   ch_q [`FW_NUM_CH][$];
    int                    off_m [`FW_NUM_CH];
    logic                  slot_m [`FW_NUM_CH];
    int                    frame_idx [`FW_NUM_CH];   // burst position inside the frame
    int                    ptr_m;
    frame_wr_pkg::ch_idx_t cur_ch;
    logic                  cur_last;
    logic                  busy;          // burst between AW and B
    logic                  pop_pend;
    logic                  resp_pend;
    logic                  b_seen;
    int                    beat;
    logic [`FW_NUM_CH-1:0] cur_mask;
    int                    cur_bpf;
    int                    cur_stall;
    int                    cur_count;
    int                    row_done;
    int                    row_errs;
    int                    errors;
    int                    checks;

    frame_writer_top frame_writer_top_inst (
        .clk       (clk),
        .rst       (rst),
        .ch_status (ch_status),
        .ch_data   (ch_data),
        .ch_pop    (ch_pop),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready)
    );

    always #50 clk = ~clk;

    function automatic frame_wr_pkg::data_t rand_word();
        frame_wr_pkg::data_t d;
        for (int k = 0; k < `FW_DATA_W / 32; k++) begin
            d[k*32 +: 32] = $urandom();
        end
        return d;
    endfunction

    function automatic logic draw_ready();
        return ($urandom() % 4) >= 32'(cur_stall);
    endfunction

    // first enabled channel at or after the pointer
    function automatic frame_wr_pkg::ch_idx_t next_channel(input int ptr);
        int idx;
        for (int k = 0; k < `FW_NUM_CH; k++) begin
            idx = (ptr + k) % `FW_NUM_CH;
            if (cur_mask[idx]) begin
                return frame_wr_pkg::ch_idx_t'(idx);
            end
        end
        return '0;
    endfunction

    function automatic frame_wr_pkg::addr_t expected_addr(input frame_wr_pkg::ch_idx_t c);
        int a;
        a = int'(c) * `FW_REGION_BYTES + (slot_m[c] ? `FW_FRAME_BYTES : 0) + off_m[c];
        return frame_wr_pkg::addr_t'(a);
    endfunction

    task automatic aw_compare(input string name, input frame_wr_pkg::axi_aw_t got,
                              input frame_wr_pkg::axi_aw_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_errs++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic w_compare(input string name, input frame_wr_pkg::axi_w_t got,
                             input frame_wr_pkg::axi_w_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_errs++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic ch_compare(input string name, input frame_wr_pkg::ch_idx_t got,
                              input frame_wr_pkg::ch_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_errs++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic flag_compare(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_errs++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        row_errs++;
        $display("At %0t %s", $time, what);
    endtask

    // effects of the handshakes taken on the last rising edge
    task automatic apply_pending();
        if (pop_pend) begin
            void'(ch_q[cur_ch].pop_front());
            pop_pend = 1'b0;
        end
        if (b_seen) begin
            if (cur_last) begin
                off_m[cur_ch]  = 0;
                slot_m[cur_ch] = ~slot_m[cur_ch];
            end else begin
                off_m[cur_ch] = off_m[cur_ch] + `FW_BURST_BYTES;
            end
            ptr_m             = (int'(cur_ch) + 1) % `FW_NUM_CH;
            frame_idx[cur_ch] = (frame_idx[cur_ch] + 1) % cur_bpf;
            row_done++;
            busy    = 1'b0;
            b_seen  = 1'b0;
            b_valid = 1'b0;
        end
    endtask

    task automatic drive_inputs();
        for (int c = 0; c < `FW_NUM_CH; c++) begin
            if (cur_mask[c]) begin
                while (ch_q[c].size() < 2 * `FW_BURST_LEN) begin
                    ch_q[c].push_back(rand_word());
                end
            end
            ch_data[c] = (ch_q[c].size() > 0) ? ch_q[c][0] : '0;
            ch_status[c].burst_ready = cur_mask[c] && (ch_q[c].size() >= `FW_BURST_LEN)
                                     && (row_done < cur_count);
            ch_status[c].last_burst  = (frame_idx[c] == cur_bpf - 1);
        end
        aw_ready = draw_ready();
        w_ready  = draw_ready();
        if (resp_pend && !b_valid && draw_ready()) begin
            b.id      = cur_ch;
            b.resp    = 2'b00;     // OKAY
            b_valid   = 1'b1;
            resp_pend = 1'b0;
        end
    endtask

    // handshakes that complete on the coming rising edge
    task automatic sample_outputs();
        frame_wr_pkg::axi_aw_t exp_aw;
        frame_wr_pkg::axi_w_t  exp_w;
        frame_wr_pkg::ch_idx_t popped;
        int                    pop_bits;
        // response ready only from after the last beat until the response
        flag_compare("b_ready", b_ready, busy && (beat == `FW_BURST_LEN));
        if (aw_valid && aw_ready) begin
            if (busy) begin
                report_failure("an address was accepted while a burst was outstanding");
            end
            cur_ch       = next_channel(ptr_m);
            cur_last     = (frame_idx[cur_ch] == cur_bpf - 1);
            exp_aw.addr  = expected_addr(cur_ch);
            exp_aw.id    = cur_ch;
            exp_aw.len   = 8'(`FW_BURST_LEN - 1);
            exp_aw.size  = 3'd5;    // 32 bytes per beat
            exp_aw.burst = 2'b01;
            aw_compare("aw", aw, exp_aw);
            ch_compare("aw.id", aw.id, cur_ch);
            busy = 1'b1;
            beat = 0;
        end
        pop_bits = 0;
        popped   = '0;
        for (int c = 0; c < `FW_NUM_CH; c++) begin
            if (ch_pop[c]) begin
                pop_bits++;
                popped = frame_wr_pkg::ch_idx_t'(c);
            end
        end
        if (w_valid && w_ready) begin
            if (!busy || ch_q[cur_ch].size() == 0) begin
                report_failure("a data beat was accepted with no burst in progress");
            end else begin
                exp_w.data = ch_q[cur_ch][0];
                exp_w.strb = '1;
                exp_w.last = (beat == `FW_BURST_LEN - 1);
                w_compare("w", w, exp_w);
                if (pop_bits != 1) begin
                    report_failure($sformatf("a data beat popped %0d channels", pop_bits));
                end else begin
                    ch_compare("ch_pop", popped, cur_ch);
                end
                pop_pend = 1'b1;
                beat++;
                if (exp_w.last) begin
                    resp_pend = 1'b1;
                end
            end
        end else if (pop_bits != 0) begin
            report_failure("a channel was popped without a data handshake");
        end
        if (b_valid && b_ready) begin
            b_seen = 1'b1;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        apply_pending();
        drive_inputs();
        #1;
        sample_outputs();
    endtask

    initial begin
        int cyc;
        int limit;
        int assert_errs;
        void'($urandom(32'h956833b8));
        rows[0] = '{5'b11111, 4, 0, 15};   // plain round robin
        rows[1] = '{5'b10101, 2, 0, 9};    // idle channels skipped
        rows[2] = '{5'b11111, 3, 2, 12};
        rows[3] = '{5'b01010, 1, 3, 6};    // every burst closes a frame
        rows[4] = '{5'b11111, 4, 1, 10};
        rst      = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b        = '0;
        b_valid  = 1'b0;
        for (int c = 0; c < `FW_NUM_CH; c++) begin
            ch_status[c] = '0;
            ch_data[c]   = '0;
            off_m[c]     = 0;
            slot_m[c]    = 1'b0;
            frame_idx[c] = 0;
        end
        ptr_m     = 0;
        cur_ch    = '0;
        cur_last  = 1'b0;
        busy      = 1'b0;
        pop_pend  = 1'b0;
        resp_pend = 1'b0;
        b_seen    = 1'b0;
        beat      = 0;
        cur_mask  = '0;
        cur_bpf   = 1;
        cur_stall = 0;
        cur_count = 0;
        errors    = 0;
        checks    = 0;
        repeat (16) @(negedge clk);
        rst = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_mask  = rows[r].mask;
            cur_bpf   = rows[r].bpf;
            cur_stall = rows[r].stall;
            cur_count = rows[r].count;
            row_done  = 0;
            row_errs  = 0;
            for (int c = 0; c < `FW_NUM_CH; c++) begin
                frame_idx[c] = 0;   // each row starts a new frame
            end
            limit = cur_count * 300;
            cyc   = 0;
            while (row_done < cur_count && cyc < limit) begin
                step_cycle();
                cyc++;
            end
            if (row_done < cur_count) begin
                $display("row %0d timed out after %0d cycles with %0d of %0d bursts done",
                         r, cyc, row_done, cur_count);
                $display("Simulation failed");
                $finish;
            end
            $display("row %0d: mask %b, %0d bursts per frame, stall %0d, %0d bursts, %0d errors",
                     r, cur_mask, cur_bpf, cur_stall, row_done, row_errs);
        end
        assert_errs = frame_writer_top_inst.frame_writer_checker_inst.assert_errs;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_errs);
        if (errors == 0 && assert_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verif/frame_writer_checker.sv */
`timescale 1ns/1ps
`include "frame_wr_defs.svh"

module frame_writer_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  frame_wr_pkg::axi_aw_t aw,
    input  logic                  aw_valid,
    input  logic                  aw_ready,
    input  frame_wr_pkg::axi_w_t  w,
    input  logic                  w_valid,
    input  logic                  w_ready,
    input  logic [`FW_NUM_CH-1:0] ch_pop
);

    logic [3:0] beat;           // W beats accepted so far in this burst
    int aw_errs   = 0;
    int w_errs    = 0;
    int last_errs = 0;
    int pop_errs  = 0;
    int assert_errs;            // read by the testbench at the end

    assign assert_errs = aw_errs + w_errs + last_errs + pop_errs;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat <= '0;
        end else if (w_valid && w_ready) begin
            beat <= beat + 1'b1;    // wraps after beat 16
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin
            aw_errs = aw_errs + 1;
            $error("aw dropped or changed before it was accepted");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else begin
            w_errs = w_errs + 1;
            $error("w dropped or changed before it was accepted");
        end

    // wlast only on beat 16
    last_beat: assert property (@(posedge clk) disable iff (!rst)
        w_valid && w_ready |-> (w.last == (beat == 4'd15)))
        else begin
            last_errs = last_errs + 1;
            $error("w last does not match beat %0d", beat);
        end

    one_pop: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(ch_pop))
        else begin
            pop_errs = pop_errs + 1;
            $error("more than one channel popped, ch_pop %b", ch_pop);
        end

endmodule

bind frame_writer_top frame_writer_checker frame_writer_checker_inst (
    .clk      (clk),
    .rst      (rst),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .ch_pop   (ch_pop)
);

/* design/frame_writer_top.sv */
`timescale 1ns/1ps
`include "frame_wr_defs.svh"

module frame_writer_top (
    input  logic                     clk,
    input  logic                     rst,
    // channel line buffers
    input  frame_wr_pkg::ch_status_t ch_status [`FW_NUM_CH],
    input  frame_wr_pkg::data_t      ch_data [`FW_NUM_CH],
    output logic [`FW_NUM_CH-1:0]    ch_pop,
    // AXI write port to DDR
    output frame_wr_pkg::axi_aw_t    aw,
    output logic                     aw_valid,
    input  logic                     aw_ready,
    output frame_wr_pkg::axi_w_t     w,
    output logic                     w_valid,
    input  logic                     w_ready,
    input  frame_wr_pkg::axi_b_t     b,
    input  logic                     b_valid,
    output logic                     b_ready
);

    logic                  grant_valid;
    frame_wr_pkg::ch_idx_t grant_ch;
    frame_wr_pkg::addr_t   burst_addr;
    logic                  last_flag;    // latched at grant
    logic                  burst_done;   // B handshake

    channel_scheduler channel_scheduler_inst (
        .clk         (clk),
        .rst         (rst),
        .ch_status   (ch_status),
        .burst_done  (burst_done),
        .grant_valid (grant_valid),
        .grant_ch    (grant_ch)
    );

    frame_addr_gen frame_addr_gen_inst (
        .clk        (clk),
        .rst        (rst),
        .grant_ch   (grant_ch),
        .burst_done (burst_done),
        .last_flag  (last_flag),
        .burst_addr (burst_addr)
    );

    axi_burst_writer axi_burst_writer_inst (
        .clk         (clk),
        .rst         (rst),
        .grant_valid (grant_valid),
        .grant_ch    (grant_ch),
        .burst_addr  (burst_addr),
        .ch_status   (ch_status),
        .ch_data     (ch_data),
        .ch_pop      (ch_pop),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .last_flag   (last_flag),
        .burst_done  (burst_done)
    );

endmodule

/* design/axi_burst_writer.sv */
`timescale 1ns/1ps
`include "frame_wr_defs.svh"

module axi_burst_writer (
    input  logic                     clk,
    input  logic                     rst,
    // from scheduler and address generator
    input  logic                     grant_valid,
    input  frame_wr_pkg::ch_idx_t    grant_ch,
    input  frame_wr_pkg::addr_t      burst_addr,
    // channel buffers
    input  frame_wr_pkg::ch_status_t ch_status [`FW_NUM_CH],
    input  frame_wr_pkg::data_t      ch_data [`FW_NUM_CH],
    output logic [`FW_NUM_CH-1:0]    ch_pop,
    // AXI write address
    output frame_wr_pkg::axi_aw_t    aw,
    output logic                     aw_valid,
    input  logic                     aw_ready,
    // AXI write data
    output frame_wr_pkg::axi_w_t     w,
    output logic                     w_valid,
    input  logic                     w_ready,
    // AXI write response
    input  frame_wr_pkg::axi_b_t     b,
    input  logic                     b_valid,
    output logic                     b_ready,
    // burst bookkeeping
    output logic                     last_flag,
    output logic                     burst_done
);

    localparam int BEAT_W = $clog2(`FW_BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`FW_BURST_LEN - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } wr_state_t;

    wr_state_t         state;
    logic [BEAT_W-1:0] beat_cnt;
    logic              aw_hs;
    logic              w_hs;

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;

    // address payload only changes between bursts
    assign aw.addr  = burst_addr;
    assign aw.id    = grant_ch;
    assign aw.len   = 8'(`FW_BURST_LEN - 1);
    assign aw.size  = 3'($clog2(`FW_DATA_W / 8));
    assign aw.burst = 2'b01;                        // INCR
    assign aw_valid = (state == ST_ADDR);

    // FWFT head word of the granted channel
    assign w.data  = ch_data[grant_ch];
    assign w.strb  = '1;
    assign w.last  = (beat_cnt == LAST_BEAT);
    assign w_valid = (state == ST_DATA);

    assign b_ready = (state == ST_RESP);

    // a response for another id is taken but does not close the burst
    assign burst_done = b_valid && b_ready && (b.id == grant_ch);

    // pop exactly on the accepted beat
    always_comb begin
        ch_pop = '0;
        if (w_hs) begin
            ch_pop[grant_ch] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= ST_IDLE;
            beat_cnt  <= '0;
            last_flag <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_valid) begin
                        state     <= ST_ADDR;
                        last_flag <= ch_status[grant_ch].last_burst;   // frame end of this burst
                    end
                end
                ST_ADDR: begin
                    if (aw_hs) begin
                        state    <= ST_DATA;
                        beat_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (w.last) begin
                            state <= ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    if (burst_done) begin
                        state <= ST_IDLE;   // scheduler drops the grant on the same edge
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/frame_addr_gen.sv */
`timescale 1ns/1ps
`include "frame_wr_defs.svh"

module frame_addr_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  frame_wr_pkg::ch_idx_t grant_ch,
    input  logic                  burst_done,
    input  logic                  last_flag,
    output frame_wr_pkg::addr_t   burst_addr
);

    frame_wr_pkg::offset_t burst_off [`FW_NUM_CH];  // next burst inside the slot
    logic [`FW_NUM_CH-1:0] slot;                    // ping-pong slot per channel

    frame_wr_pkg::addr_t region_base;
    frame_wr_pkg::addr_t slot_base;

    // channel region, then slot, then offset
    assign region_base = frame_wr_pkg::addr_t'(grant_ch)
                       * frame_wr_pkg::addr_t'(`FW_REGION_BYTES);

    assign slot_base = slot[grant_ch] ? frame_wr_pkg::addr_t'(`FW_FRAME_BYTES) : '0;

    assign burst_addr = region_base + slot_base
                      + frame_wr_pkg::addr_t'(burst_off[grant_ch]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `FW_NUM_CH; i++) begin
                burst_off[i] <= '0;
            end
            slot <= '0;
        end else if (burst_done) begin
            if (last_flag) begin
                // frame closed so the next one goes to the other slot
                burst_off[grant_ch] <= '0;
                slot[grant_ch]      <= ~slot[grant_ch];
            end else begin
                burst_off[grant_ch] <= burst_off[grant_ch]
                                     + frame_wr_pkg::offset_t'(`FW_BURST_BYTES);
            end
        end
    end

endmodule

/* design/channel_scheduler.sv */
`timescale 1ns/1ps
`include "frame_wr_defs.svh"

module channel_scheduler (
    input  logic                     clk,
    input  logic                     rst,
    input  frame_wr_pkg::ch_status_t ch_status [`FW_NUM_CH],
    input  logic                     burst_done,
    output logic                     grant_valid,
    output frame_wr_pkg::ch_idx_t    grant_ch
);

    localparam frame_wr_pkg::ch_idx_t LAST_CH = frame_wr_pkg::ch_idx_t'(`FW_NUM_CH - 1);

    frame_wr_pkg::ch_idx_t rr_ptr;      // first channel to look at
    frame_wr_pkg::ch_idx_t pick_ch;
    logic                  pick_valid;

    // first ready channel at or after the pointer, wrapping at FW_NUM_CH
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_ch    = rr_ptr;
        for (int k = 0; k < `FW_NUM_CH; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= `FW_NUM_CH) begin
                idx = idx - `FW_NUM_CH;
            end
            if (!pick_valid && ch_status[idx].burst_ready) begin
                pick_valid = 1'b1;
                pick_ch    = frame_wr_pkg::ch_idx_t'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            grant_valid <= 1'b0;
            grant_ch    <= '0;
            rr_ptr      <= '0;
        end else if (grant_valid) begin
            // grant held for the whole burst
            if (burst_done) begin
                grant_valid <= 1'b0;
                rr_ptr      <= (grant_ch == LAST_CH) ? '0 : grant_ch + 1'b1;
            end
        end else if (pick_valid) begin
            grant_valid <= 1'b1;
            grant_ch    <= pick_ch;
        end
    end

endmodule

/* design/frame_wr_pkg.sv */
`include "frame_wr_defs.svh"

package frame_wr_pkg;

    typedef logic [`FW_DATA_W-1:0]   data_t;     // one beat
    typedef logic [`FW_CH_W-1:0]     ch_idx_t;
    typedef logic [`FW_ADDR_W-1:0]   addr_t;     // DDR byte address
    typedef logic [`FW_OFFSET_W-1:0] offset_t;   // byte offset inside a slot

    // status of one channel line buffer
    typedef struct packed {
        logic burst_ready;  // 16 beats or more buffered
        logic last_burst;   // those beats close the frame
    } ch_status_t;

    // write address channel
    typedef struct packed {
        addr_t      addr;
        ch_idx_t    id;     // channel index
        logic [7:0] len;    // beats - 1
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        data_t                  data;
        logic [`FW_DATA_W/8-1:0] strb;
        logic                   last;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        ch_idx_t    id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

/* include/frame_wr_defs.svh */
`ifndef FRAME_WR_DEFS_SVH
`define FRAME_WR_DEFS_SVH

// channel side
`define FW_NUM_CH       5           // video channels
`define FW_CH_W         3           // bits of a channel index

// AXI write port
`define FW_ADDR_W       28          // DDR byte address
`define FW_DATA_W       256         // one beat
`define FW_BURST_LEN    16          // beats per burst
`define FW_BURST_BYTES  512         // FW_BURST_LEN * FW_DATA_W / 8

// each channel region in DDR holds two frame slots
`define FW_FRAME_BYTES  'h40000     // one slot
`define FW_REGION_BYTES 'h80000     // two slots per channel
`define FW_OFFSET_W     18          // burst offset inside a slot

`endif
